// File: Bender.yml
package:
  name: rvCore

sources:
  - files:
      - verilog/rvPkg.sv
      - verilog/regFile.sv
      - verilog/fetchDecode.sv
      - verilog/pipeControl.sv
      - verilog/execUnit.sv
      - verilog/memWriteback.sv
      - verilog/rvCore.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tbRvCore.sv

// File: bench/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

////////////////////
// immediates, straight from the encoding tables
////////////////////
function automatic logic [XLEN-1:0] immI(input logic [XLEN-1:0] i);
  return {{20{i[31]}}, i[31:20]};
endfunction

function automatic logic [XLEN-1:0] immS(input logic [XLEN-1:0] i);
  return {{20{i[31]}}, i[31:25], i[11:7]};
endfunction

function automatic logic [XLEN-1:0] immB(input logic [XLEN-1:0] i);
  return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
endfunction

function automatic logic [XLEN-1:0] immJ(input logic [XLEN-1:0] i);
  return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
endfunction

function automatic logic [XLEN-1:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
  logic [XLEN-1:0] sra;
  sra = $signed(a) >>> b[4:0];
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011:  return (a < b) ? 32'd1 : 32'd0;
    3'b100:  return a ^ b;
    3'b101:  return alt ? sra : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branchRef(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                   input logic [XLEN-1:0] b);
  case (f3)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return $signed(a) < $signed(b);
    3'b101:  return $signed(a) >= $signed(b);
    3'b110:  return a < b;
    default: return a >= b;
  endcase
endfunction

// architectural model, one instruction per step, stops after the jal-to-self
function automatic void runModel(input logic [XLEN-1:0] prg [$], output retireT exp [$]);
  logic [XLEN-1:0] x [32];
  logic [XLEN-1:0] dm [int];
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] inst;
  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic [XLEN-1:0] res;
  logic [XLEN-1:0] nextPc;
  logic [XLEN-1:0] addr;
  logic [2:0]      f3;
  logic            wr;
  logic            halt;
  retireT          r;
  exp = {};
  foreach (x[i]) x[i] = '0;
  pc   = '0;
  halt = 1'b0;
  while (!halt && exp.size() < MODEL_STEP_LIMIT) begin
    inst   = prg[pc >> 2];
    f3     = inst[14:12];
    a      = x[inst[19:15]];
    b      = x[inst[24:20]];
    res    = '0;
    wr     = 1'b0;
    nextPc = pc + 4;
    case (inst[6:0])
      OPC_OP: begin
        res = aluRef(f3, inst[30], a, b);
        wr  = 1'b1;
      end
      OPC_OP_IMM: begin
        res = aluRef(f3, inst[30] && f3 == 3'b101, a, immI(inst)); // only srai uses bit 30
        wr  = 1'b1;
      end
      OPC_LUI: begin
        res = {inst[31:12], 12'b0};
        wr  = 1'b1;
      end
      OPC_LOAD: begin
        addr = a + immI(inst);
        res  = dm[int'((addr >> 2) % DMEM_WORDS)];
        wr   = 1'b1;
      end
      OPC_STORE: begin
        addr = a + immS(inst);
        dm[int'((addr >> 2) % DMEM_WORDS)] = b;
      end
      OPC_BRANCH: if (branchRef(f3, a, b)) nextPc = pc + immB(inst);
      OPC_JAL: begin
        res    = pc + 4;
        wr     = 1'b1;
        nextPc = pc + immJ(inst);
        halt   = (immJ(inst) == '0);
      end
      default: ;
    endcase
    r.valid    = 1'b1;
    r.pc       = pc;
    r.regWrite = wr;
    r.rd       = wr ? inst[11:7] : '0;
    r.data     = (wr && inst[11:7] != '0) ? res : '0;
    exp.push_back(r);
    if (wr && inst[11:7] != '0) x[inst[11:7]] = res;
    pc = nextPc;
  end
endfunction

`endif

// File: bench/tbRvCore.sv
`timescale 1ns/10ps
`default_nettype none

module tbRvCore;
  import rvPkg::*;

  localparam int          RESET_CYCLES      = 16;
  localparam int          RANDOM_OPS        = 40;
  localparam int          CYCLES_PER_RETIRE = 12;
  localparam int          WATCHDOG_MARGIN   = 100;
  localparam int          MODEL_STEP_LIMIT  = 1000;
  localparam int          DRAIN_CYCLES      = 2;  // slots flushed behind the halt jal
  localparam logic [31:0] LFSR_SEED         = 32'h76e4b7ca;
  localparam logic [31:0] LFSR_TAPS         = 32'h8020_0003;

  logic   clk;
  logic   rst;
  progT   prog;
  retireT retire;

  logic [31:0]     lfsr;
  logic [XLEN-1:0] code [$];
  logic [11:0]     storedOffs [$];  // offsets from x8 that hold data
  retireT          expQ [$];
  logic [2:0]      brKinds [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
  int              expTotal;
  int              loadCycles;
  int              retired;
  int              mismatches;
  int              orderErrors;
  logic            modelReady;

  `include "isaModel.svh"

  rvCore dut0 (
    .clk    (clk),
    .rst    (rst),
    .prog   (prog),
    .retire (retire)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // stimulus helpers
  ////////////////////
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? (lfsr >> 1) ^ LFSR_TAPS : lfsr >> 1; // galois step
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encodeS(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE}; // sw
  endfunction

  function automatic logic [31:0] encodeB(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] encodeJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [31:0] encodeU(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_LUI};
  endfunction

  // reg-reg, reg-imm or lui on x0..x7
  function automatic logic [31:0] randomAlu();
    logic [2:0] f3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [1:0] form;
    logic       alt;
    f3   = 3'(randBits(3));
    rd   = 5'(randBits(3));
    rs1  = 5'(randBits(3));
    rs2  = 5'(randBits(3));
    form = 2'(randBits(2));
    alt  = randBits(1) && (f3 == 3'b000 || f3 == 3'b101); // sub or sra
    case (form)
      2'd0, 2'd1: return encodeR(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
      2'd2: begin
        if (f3 == 3'b001 || f3 == 3'b101)
          return encodeI({(alt ? 7'h20 : 7'h00), 5'(randBits(5))}, rs1, f3, rd, OPC_OP_IMM);
        return encodeI(12'(randBits(12)), rs1, f3, rd, OPC_OP_IMM);
      end
      default: return encodeU(20'(randBits(20)), rd);
    endcase
  endfunction

  task automatic addWord(input logic [XLEN-1:0] w);
    code.push_back(w);
  endtask

  task automatic buildProgram();
    logic [XLEN-1:0] inc;
    logic [11:0]     off;
    logic [4:0]      rd;
    logic [2:0]      kind;
    int              skip;
    inc = encodeI(12'd1, 5'd13, 3'b000, 5'd13, OPC_OP_IMM); // x13 counts skipped slots
    code = {};
    for (int r = 1; r <= 7; r++) begin
      addWord(encodeU(20'(randBits(20)), 5'(r)));
      addWord(encodeI(12'(randBits(12)), 5'(r), 3'b000, 5'(r), OPC_OP_IMM));
    end
    addWord(encodeU(20'(randBits(20)), 5'd8)); // data base, never overwritten
    addWord(encodeI(12'd0, 5'd0, 3'b000, 5'd13, OPC_OP_IMM));

    // load-use against alu, store data and branch operands
    addWord(encodeS(12'd0, 5'd1, 5'd8));
    addWord(encodeS(12'hffc, 5'd2, 5'd8)); // wraps to the top word
    addWord(encodeI(12'd0, 5'd8, 3'b010, 5'd9, OPC_LOAD));
    addWord(encodeR(7'h00, 5'd9, 5'd9, 3'b000, 5'd10));
    addWord(encodeI(12'hffc, 5'd8, 3'b010, 5'd11, OPC_LOAD));
    addWord(encodeS(12'd8, 5'd11, 5'd8));
    addWord(encodeI(12'd8, 5'd8, 3'b010, 5'd12, OPC_LOAD));
    addWord(encodeB(13'd8, 5'd11, 5'd12, 3'b000));
    addWord(inc);
    storedOffs = '{12'd0, 12'hffc, 12'd8};

    // every branch kind, taken and not taken
    addWord(encodeI(12'hffb, 5'd0, 3'b000, 5'd14, OPC_OP_IMM)); // -5
    addWord(encodeI(12'd3, 5'd0, 3'b000, 5'd15, OPC_OP_IMM));
    foreach (brKinds[k]) begin
      addWord(encodeB(13'd8, 5'd15, 5'd14, brKinds[k]));
      addWord(inc);
      addWord(encodeB(13'd8, 5'd14, 5'd15, brKinds[k]));
      addWord(inc);
      addWord(encodeB(13'd8, 5'd14, 5'd14, brKinds[k]));
      addWord(inc);
    end

    addWord(encodeJ(21'd12, 5'd16)); // link read back below
    addWord(inc);
    addWord(inc);
    addWord(encodeR(7'h00, 5'd0, 5'd16, 3'b000, 5'd17));
    addWord(encodeI(12'd5, 5'd1, 3'b000, 5'd0, OPC_OP_IMM)); // write to x0
    addWord(encodeR(7'h00, 5'd1, 5'd0, 3'b000, 5'd18));

    ////////////////////
    // random mix
    ////////////////////
    for (int k = 0; k < RANDOM_OPS; k++) begin
      kind = 3'(randBits(3));
      case (kind)
        3'd3: begin
          off = {10'(randBits(10)), 2'b00};
          addWord(encodeS(off, 5'(randBits(3)), 5'd8));
          storedOffs.push_back(off);
        end
        3'd4: begin
          rd = 5'(randBits(3));
          off = storedOffs[randBits(8) % storedOffs.size()];
          addWord(encodeI(off, 5'd8, 3'b010, rd, OPC_LOAD));
          addWord(encodeR(7'h00, 5'(randBits(3)), rd, 3'b000, 5'(randBits(3)))); // use at once
        end
        3'd5, 3'd6: begin
          skip = 1 + int'(randBits(1));
          if (kind == 3'd5)
            addWord(encodeB(13'(4 * (skip + 1)), 5'(randBits(3)), 5'(randBits(3)),
                            brKinds[randBits(8) % 6]));
          else
            addWord(encodeJ(21'(4 * (skip + 1)), 5'(randBits(3))));
          repeat (skip) addWord(randomAlu());
        end
        default: addWord(randomAlu());
      endcase
    end
    addWord(encodeJ(21'd0, 5'd0)); // halt, jumps to itself
    for (int k = 0; k < 2; k++)
      addWord(encodeI(12'(code.size()), 5'd0, 3'b000, 5'd0, OPC_OP_IMM));
  endtask

  ////////////////////
  // checks
  ////////////////////
  // rd and data only mean something for a write to x1..x31
  function automatic retireT maskRetire(input retireT r);
    if (!r.regWrite) begin
      r.rd   = '0;
      r.data = '0;
    end else if (r.rd == '0) begin
      r.data = '0;
    end
    return r;
  endfunction

  task automatic checkRetire(input string name, input retireT got, input retireT exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch %s at pc %h: got %h expected %h", name, exp.pc, got, exp);
    end
  endtask

  task automatic checkData(input string name, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic printCounts();
    $display("errors: %0d mismatched, %0d missing or extra, %0d of %0d retirements checked",
             mismatches, orderErrors, retired, expTotal);
  endtask

  // outputs settle after the rising edge, sample on the falling one
  always @(negedge clk) begin
    if (rst) begin
      if (retire.valid === 1'b1) begin
        orderErrors++;
        $display("Error: a retirement appeared while reset was high");
      end
    end else if (retire.valid === 1'b1) begin
      if (expQ.size() == 0) begin
        orderErrors++;
        $display("Error: unexpected retirement at pc %h after the program ended", retire.pc);
      end else begin
        if (retired == 0) checkData("retire.pc", retire.pc, '0);
        checkRetire("retire", maskRetire(retire), expQ.pop_front());
        retired++;
      end
    end else if (retire.valid !== 1'b0) begin
      orderErrors++;
      $display("Error: retire.valid is unknown out of reset");
    end
  end

  initial begin
    modelReady  = 1'b0;
    rst         = 1'b1;
    prog        = '0;
    retired     = 0;
    mismatches  = 0;
    orderErrors = 0;
    lfsr        = LFSR_SEED;
    buildProgram();
    runModel(code, expQ);
    expTotal   = expQ.size();
    loadCycles = (code.size() > RESET_CYCLES) ? code.size() : RESET_CYCLES;
    modelReady = 1'b1;

    // program goes in while the core is held in reset
    for (int i = 0; i < loadCycles; i++) begin
      @(posedge clk);
      #1;
      prog.we   = (i < code.size());
      prog.addr = IMEM_ADDR_BITS'(i);
      prog.data = (i < code.size()) ? code[i] : '0;
    end
    @(posedge clk);
    #1;
    prog = '0;
    rst  = 1'b0;

    while (expQ.size() != 0) @(posedge clk);
    // the two words behind the halt must never retire
    repeat (DRAIN_CYCLES) @(posedge clk);
    printCounts();
    if (mismatches == 0 && orderErrors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    wait (modelReady === 1'b1);
    repeat (loadCycles + CYCLES_PER_RETIRE * expTotal + WATCHDOG_MARGIN) @(posedge clk);
    $display("Error: timed out with %0d of %0d retirements never seen", expQ.size(), expTotal);
    orderErrors += expQ.size();
    printCounts();
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+bench
verilog/rvPkg.sv
verilog/regFile.sv
verilog/fetchDecode.sv
verilog/pipeControl.sv
verilog/execUnit.sv
verilog/memWriteback.sv
verilog/rvCore.sv
bench/tbRvCore.sv

// File: verilog/execUnit.sv
`timescale 1ns/10ps
`default_nettype none

module execUnit (
  input  logic                   clk,
  input  logic                   rst,
  input  rvPkg::idExT            idEx,
  input  rvPkg::fwdSelT          fwdA,
  input  rvPkg::fwdSelT          fwdB,
  input  logic [rvPkg::XLEN-1:0] wbData,
  output rvPkg::exMemT           exMem,
  output rvPkg::redirectT        redirect
);
  import rvPkg::*;

  logic [XLEN-1:0]       rs1v;
  logic [XLEN-1:0]       rs2v;
  logic [XLEN-1:0]       opA;
  logic [XLEN-1:0]       opB;
  logic [SHAMT_BITS-1:0] shamt;
  logic [XLEN-1:0]       aluRes;
  logic                  brEq;
  logic                  brLt;
  logic                  brCond;

  function automatic logic [XLEN-1:0] fwdMux(input fwdSelT sel,
                                              input logic [XLEN-1:0] regVal,
                                              input logic [XLEN-1:0] memVal,
                                              input logic [XLEN-1:0] wbVal);
    case (sel)
      FWD_MEM: return memVal;
      FWD_WB:  return wbVal;
      default: return regVal;
    endcase
  endfunction

  ////////////////////
  // operands
  ////////////////////
  assign rs1v = fwdMux(fwdA, idEx.rs1Val, exMem.aluRes, wbData);
  assign rs2v = fwdMux(fwdB, idEx.rs2Val, exMem.aluRes, wbData);

  assign opA = idEx.ctrl.aIsPc ? idEx.pc : rs1v;

  // jal goes through the adder as pc + 4
  always_comb begin
    if (idEx.ctrl.isJump) opB = XLEN'(4);
    else if (idEx.ctrl.bIsImm) opB = idEx.imm;
    else opB = rs2v;
  end

  assign shamt = opB[SHAMT_BITS-1:0];

  ////////////////////
  // alu
  ////////////////////
  always_comb begin
    case (idEx.ctrl.aluOp)
      ALU_ADD:   aluRes = opA + opB;
      ALU_SUB:   aluRes = opA - opB;
      ALU_AND:   aluRes = opA & opB;
      ALU_OR:    aluRes = opA | opB;
      ALU_XOR:   aluRes = opA ^ opB;
      ALU_SLT:   aluRes = XLEN'($signed(opA) < $signed(opB));
      ALU_SLTU:  aluRes = XLEN'(opA < opB);
      ALU_SLL:   aluRes = opA << shamt;
      ALU_SRL:   aluRes = opA >> shamt;
      ALU_SRA:   aluRes = $signed(opA) >>> shamt;
      ALU_PASSB: aluRes = opB;
      default:   aluRes = opA + opB;
    endcase
  end

  ////////////////////
  // branch and jump
  ////////////////////
  assign brEq = (rs1v == rs2v);

  // funct3[1] picks unsigned, funct3[0] inverts the test
  assign brLt = idEx.ctrl.funct3[1] ? (rs1v < rs2v) : ($signed(rs1v) < $signed(rs2v));

  assign brCond = idEx.ctrl.funct3[2] ? (brLt ^ idEx.ctrl.funct3[0])
                                      : (brEq ^ idEx.ctrl.funct3[0]);

  always_comb begin
    redirect.taken  = idEx.valid && (idEx.ctrl.isJump || (idEx.ctrl.isBranch && brCond));
    redirect.target = idEx.pc + idEx.imm; // same adder for branch and jal
  end

  // EX/MEM
  always_ff @(posedge clk) begin
    if (rst) begin
      exMem.valid <= 1'b0;
      exMem.ctrl  <= '0;
    end else begin
      exMem.valid <= idEx.valid;
      exMem.ctrl  <= idEx.valid ? idEx.ctrl : '0; // bubble
    end
    exMem.pc        <= idEx.pc;
    exMem.aluRes    <= aluRes;
    exMem.storeData <= rs2v;
  end

endmodule

`default_nettype wire

// File: verilog/fetchDecode.sv
`timescale 1ns/10ps
`default_nettype none

module fetchDecode (
  input  logic            clk,
  input  logic            rst,
  input  rvPkg::progT     prog,
  input  rvPkg::ctrlT     ctrl,
  input  logic            stall,
  input  logic            flush,
  input  rvPkg::redirectT redirect,
  input  rvPkg::retireT   rfWrite,
  output rvPkg::instT     decInst,
  output rvPkg::idExT     idEx
);
  import rvPkg::*;

  logic [XLEN-1:0] imem [IMEM_WORDS];
  logic [XLEN-1:0] pc;
  instT            fetchInst;
  logic            ifIdValid;
  logic [XLEN-1:0] ifIdPc;
  instT            ifIdInst;
  rViewT           rv;
  iViewT           iv;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] rdata1;
  logic [XLEN-1:0] rdata2;
  logic            usesRs1;
  logic            usesRs2;
  logic            idValid;

  ////////////////////
  // fetch
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst && prog.we) imem[prog.addr] <= prog.data; // loaded only under reset
  end

  assign fetchInst = imem[pc[IMEM_ADDR_BITS+1:2]];

  always_ff @(posedge clk) begin
    if (rst) pc <= '0;
    else if (flush) pc <= redirect.target;
    else if (!stall) pc <= pc + XLEN'(4);
  end

  // IF/ID, a flush only drops the valid bit
  always_ff @(posedge clk) begin
    if (rst) begin
      ifIdValid <= 1'b0;
      ifIdInst  <= INST_NOP;
    end else if (flush) begin
      ifIdValid <= 1'b0;
    end else if (!stall) begin
      ifIdValid <= 1'b1;
      ifIdInst  <= fetchInst;
      ifIdPc    <= pc;
    end
  end

  ////////////////////
  // decode
  ////////////////////
  assign decInst = ifIdInst;
  assign rv      = ifIdInst.rView;
  assign iv      = ifIdInst.iView;

  always_comb begin
    case (opcodeT'(rv.opcode))
      OPC_STORE:  imm = {{20{rv.funct7[6]}}, rv.funct7, rv.rd};
      OPC_BRANCH: imm = {{19{rv.funct7[6]}}, rv.funct7[6], rv.rd[0], rv.funct7[5:0],
                         rv.rd[4:1], 1'b0};
      OPC_JAL:    imm = {{11{rv.funct7[6]}}, rv.funct7[6], rv.rs1, rv.funct3, rv.rs2[0],
                         rv.funct7[5:0], rv.rs2[4:1], 1'b0};
      OPC_LUI:    imm = {rv.funct7, rv.rs2, rv.rs1, rv.funct3, 12'b0};
      default:    imm = {{20{iv.imm12[11]}}, iv.imm12}; // i-type
    endcase
  end

  regFile regFile0 (
    .clk    (clk),
    .rst    (rst),
    .we     (rfWrite.valid && rfWrite.regWrite),
    .waddr  (rfWrite.rd),
    .wdata  (rfWrite.data),
    .raddr1 (rv.rs1),
    .raddr2 (rv.rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  // unused source fields are zeroed so they never match a forward
  assign usesRs1 = !(ctrl.aIsPc || ctrl.aluOp == ALU_PASSB);
  assign usesRs2 = !ctrl.bIsImm || ctrl.memWrite;
  assign idValid = ifIdValid && !stall && !flush;

  // ID/EX
  always_ff @(posedge clk) begin
    if (rst) begin
      idEx.valid <= 1'b0;
      idEx.ctrl  <= '0;
      idEx.rs1   <= '0;
      idEx.rs2   <= '0;
    end else begin
      idEx.valid <= idValid;
      idEx.ctrl  <= idValid ? ctrl : '0; // bubble
      idEx.rs1   <= (idValid && usesRs1) ? rv.rs1 : '0;
      idEx.rs2   <= (idValid && usesRs2) ? rv.rs2 : '0;
    end
    idEx.pc     <= ifIdPc;
    idEx.rs1Val <= rdata1;
    idEx.rs2Val <= rdata2;
    idEx.imm    <= imm;
  end

  progOnlyInReset: assert property (@(posedge clk) !rst |-> !prog.we)
    else $error("program write while core is running");

endmodule

`default_nettype wire

// File: verilog/memWriteback.sv
`timescale 1ns/10ps
`default_nettype none

module memWriteback (
  input  logic                   clk,
  input  logic                   rst,
  input  rvPkg::exMemT           exMem,
  output logic [rvPkg::XLEN-1:0] wbData,
  output rvPkg::retireT          retire
);
  import rvPkg::*;

  logic [XLEN-1:0]           dmem [DMEM_WORDS];
  logic [DMEM_ADDR_BITS-1:0] dmIdx;
  logic                      wbValid;
  logic                      wbRegWrite;
  logic                      wbLoad;
  logic [REG_BITS-1:0]       wbRd;
  logic [XLEN-1:0]           wbPc;
  logic [XLEN-1:0]           wbAlu;
  logic [XLEN-1:0]           wbLoadData;

  assign dmIdx = exMem.aluRes[DMEM_ADDR_BITS+1:2]; // word address, wraps

  always_ff @(posedge clk) begin
    if (exMem.valid && exMem.ctrl.memWrite) dmem[dmIdx] <= exMem.storeData;
    wbLoadData <= dmem[dmIdx];
  end

  ////////////////////
  // MEM/WB
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      wbValid    <= 1'b0;
      wbRegWrite <= 1'b0;
      wbLoad     <= 1'b0;
    end else begin
      wbValid    <= exMem.valid;
      wbRegWrite <= exMem.ctrl.regWrite;
      wbLoad     <= exMem.ctrl.memRead;
    end
    wbRd  <= exMem.ctrl.rd;
    wbPc  <= exMem.pc;
    wbAlu <= exMem.aluRes;
  end

  assign wbData = wbLoad ? wbLoadData : wbAlu;

  always_comb begin
    retire.valid    = wbValid;
    retire.pc       = wbPc;
    retire.regWrite = wbRegWrite;
    retire.rd       = wbRd;
    retire.data     = wbData;
  end

endmodule

`default_nettype wire

// File: verilog/pipeControl.sv
`timescale 1ns/10ps
`default_nettype none

module pipeControl (
  input  logic            clk,
  input  logic            rst,
  input  rvPkg::instT     decInst,
  input  rvPkg::idExT     idEx,
  input  rvPkg::exMemT    exMem,
  input  rvPkg::retireT   wbRetire,
  input  rvPkg::redirectT redirect,
  output rvPkg::ctrlT     ctrl,
  output logic            stall,
  output logic            flush,
  output rvPkg::fwdSelT   fwdA,
  output rvPkg::fwdSelT   fwdB
);
  import rvPkg::*;

  logic immAlt;
  logic usesRs1;
  logic usesRs2;
  logic loadUse;
  logic squashD; // decode slot holds a flushed instruction

  function automatic aluOpT aluFromFunct(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // memory stage first, it holds the younger result
  function automatic fwdSelT pickSrc(input logic [REG_BITS-1:0] rs, input exMemT mem,
                                     input retireT wb);
    if (rs == '0) return FWD_REG;
    if (mem.valid && mem.ctrl.regWrite && mem.ctrl.rd == rs) return FWD_MEM;
    if (wb.valid && wb.regWrite && wb.rd == rs) return FWD_WB;
    return FWD_REG;
  endfunction

  ////////////////////
  // decode
  ////////////////////
  assign immAlt = (decInst.iView.funct3 == 3'b101) && decInst.rView.funct7[5]; // srai

  always_comb begin
    ctrl        = '0;
    ctrl.funct3 = decInst.rView.funct3;
    ctrl.rd     = decInst.rView.rd;
    case (opcodeT'(decInst.rView.opcode))
      OPC_OP: begin
        ctrl.aluOp    = aluFromFunct(decInst.rView.funct3, decInst.rView.funct7[5]);
        ctrl.regWrite = 1'b1;
      end
      OPC_OP_IMM: begin
        ctrl.aluOp    = aluFromFunct(decInst.iView.funct3, immAlt);
        ctrl.bIsImm   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      OPC_LUI: begin
        ctrl.aluOp    = ALU_PASSB;
        ctrl.bIsImm   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      OPC_LOAD: begin
        ctrl.bIsImm   = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      OPC_STORE: begin
        ctrl.bIsImm   = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      OPC_BRANCH: ctrl.isBranch = 1'b1;
      OPC_JAL: begin
        ctrl.aIsPc    = 1'b1; // link value is pc + 4
        ctrl.bIsImm   = 1'b1;
        ctrl.isJump   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ctrl.rd = '0; // unknown opcode acts as a nop
    endcase
  end

  ////////////////////
  // hazards
  ////////////////////
  assign usesRs1 = !(ctrl.aIsPc || ctrl.aluOp == ALU_PASSB);
  assign usesRs2 = !ctrl.bIsImm || ctrl.memWrite;

  assign loadUse = idEx.valid && idEx.ctrl.memRead && idEx.ctrl.rd != '0 &&
                   ((usesRs1 && decInst.rView.rs1 == idEx.ctrl.rd) ||
                    (usesRs2 && decInst.rView.rs2 == idEx.ctrl.rd));

  assign flush = redirect.taken;
  assign stall = loadUse && !flush && !squashD;

  always_ff @(posedge clk) begin
    if (rst) squashD <= 1'b0;
    else squashD <= flush;
  end

  assign fwdA = pickSrc(idEx.rs1, exMem, wbRetire);
  assign fwdB = pickSrc(idEx.rs2, exMem, wbRetire);

  // load data only exists in writeback, the stall must cover the gap
  noMemFwdOfLoad: assert property (
    @(posedge clk) disable iff (rst)
      (fwdA == FWD_MEM || fwdB == FWD_MEM) |-> !exMem.ctrl.memRead
  ) else $error("memory stage forward of a load");

  flushIsPulse: assert property (@(posedge clk) disable iff (rst) flush |=> !flush)
    else $error("flush held for two cycles");

endmodule

`default_nettype wire

// File: verilog/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       we,
  input  logic [rvPkg::REG_BITS-1:0] waddr,
  input  logic [rvPkg::XLEN-1:0]     wdata,
  input  logic [rvPkg::REG_BITS-1:0] raddr1,
  input  logic [rvPkg::REG_BITS-1:0] raddr2,
  output logic [rvPkg::XLEN-1:0]     rdata1,
  output logic [rvPkg::XLEN-1:0]     rdata2
);
  import rvPkg::*;

  logic [XLEN-1:0] regs [1:31]; // x0 has no storage

  always_ff @(posedge clk) begin
    if (we && waddr != '0) regs[waddr] <= wdata;
  end

  // write-before-read, a writeback in this cycle is visible to decode
  assign rdata1 = (raddr1 == '0) ? '0 :
                  (we && waddr == raddr1) ? wdata : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 :
                  (we && waddr == raddr2) ? wdata : regs[raddr2];

  ////////////////////
  // checks
  ////////////////////
  // last cycle's write is held in storage unless a newer write bypasses it
  writeReadsBack: assert property (
    @(posedge clk) disable iff (rst)
      ($past(we) && $past(waddr) != '0 && raddr1 == $past(waddr) &&
       !(we && waddr == raddr1))
        |-> rdata1 == $past(wdata)
  ) else $error("register read after a write returned stale data");

endmodule

`default_nettype wire

// File: verilog/rvCore.sv
`timescale 1ns/10ps
`default_nettype none

module rvCore (
  input  logic          clk,
  input  logic          rst,
  input  rvPkg::progT   prog,
  output rvPkg::retireT retire
);
  import rvPkg::*;

  ////////////////////
  // stage to stage
  ////////////////////
  instT     decInst;
  ctrlT     ctrl;
  logic     stall;
  logic     flush;
  idExT     idEx;
  exMemT    exMem;
  fwdSelT   fwdA;
  fwdSelT   fwdB;
  redirectT redirect;
  logic [XLEN-1:0] wbData; // writeback value, forwarded into execute

  fetchDecode fetchDecode0 (
    .clk      (clk),
    .rst      (rst),
    .prog     (prog),
    .ctrl     (ctrl),
    .stall    (stall),
    .flush    (flush),
    .redirect (redirect),
    .rfWrite  (retire),   // regfile write port comes from MEM/WB
    .decInst  (decInst),
    .idEx     (idEx)
  );

  pipeControl pipeControl0 (
    .clk      (clk),
    .rst      (rst),
    .decInst  (decInst),
    .idEx     (idEx),
    .exMem    (exMem),
    .wbRetire (retire),
    .redirect (redirect),
    .ctrl     (ctrl),
    .stall    (stall),
    .flush    (flush),
    .fwdA     (fwdA),
    .fwdB     (fwdB)
  );

  execUnit execUnit0 (
    .clk      (clk),
    .rst      (rst),
    .idEx     (idEx),
    .fwdA     (fwdA),
    .fwdB     (fwdB),
    .wbData   (wbData),
    .exMem    (exMem),
    .redirect (redirect)
  );

  memWriteback memWriteback0 (
    .clk    (clk),
    .rst    (rst),
    .exMem  (exMem),
    .wbData (wbData),
    .retire (retire)
  );

endmodule

`default_nettype wire

// File: verilog/rvPkg.sv
`default_nettype none

package rvPkg;

  ////////////////////
  // sizes
  ////////////////////
  localparam int XLEN           = 32;
  localparam int REG_BITS       = 5;
  localparam int SHAMT_BITS     = $clog2(XLEN);
  localparam int IMEM_WORDS     = 256;
  localparam int IMEM_ADDR_BITS = $clog2(IMEM_WORDS);
  localparam int DMEM_WORDS     = 256;
  localparam int DMEM_ADDR_BITS = $clog2(DMEM_WORDS);

  localparam logic [XLEN-1:0] INST_NOP = 32'h0000_0013; // addi x0, x0, 0

  // major opcodes that survive in this core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcodeT;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASSB // lui
  } aluOpT;

  ////////////////////
  // instruction word
  ////////////////////
  typedef struct packed {
    logic [6:0]          funct7;
    logic [REG_BITS-1:0] rs2;
    logic [REG_BITS-1:0] rs1;
    logic [2:0]          funct3;
    logic [REG_BITS-1:0] rd;
    logic [6:0]          opcode;
  } rViewT;

  typedef struct packed {
    logic [11:0]         imm12;
    logic [REG_BITS-1:0] rs1;
    logic [2:0]          funct3;
    logic [REG_BITS-1:0] rd;
    logic [6:0]          opcode;
  } iViewT;

  // s, b and j immediates get pieced together from rView
  typedef union packed {
    rViewT rView;
    iViewT iView;
  } instT;

  typedef struct packed {
    aluOpT               aluOp;
    logic                bIsImm;
    logic                aIsPc;
    logic                memRead;
    logic                memWrite;
    logic                regWrite;
    logic                isBranch;
    logic                isJump;
    logic [2:0]          funct3;
    logic [REG_BITS-1:0] rd;
  } ctrlT;

  typedef enum logic [1:0] {
    FWD_REG,
    FWD_MEM,
    FWD_WB
  } fwdSelT;

  ////////////////////
  // stage registers
  ////////////////////
  typedef struct packed {
    logic                valid;
    logic [XLEN-1:0]     pc;
    ctrlT                ctrl;
    logic [REG_BITS-1:0] rs1;
    logic [REG_BITS-1:0] rs2;
    logic [XLEN-1:0]     rs1Val;
    logic [XLEN-1:0]     rs2Val;
    logic [XLEN-1:0]     imm;
  } idExT;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    ctrlT            ctrl;
    logic [XLEN-1:0] aluRes;
    logic [XLEN-1:0] storeData;
  } exMemT;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
  } redirectT;

  typedef struct packed {
    logic                valid;
    logic [XLEN-1:0]     pc;
    logic                regWrite;
    logic [REG_BITS-1:0] rd;
    logic [XLEN-1:0]     data;
  } retireT;

  typedef struct packed {
    logic                      we;
    logic [IMEM_ADDR_BITS-1:0] addr;
    logic [XLEN-1:0]           data;
  } progT;

endpackage

`default_nettype wire
